//--- sources.f
rtl/array_pkg.sv
rtl/axil_config.sv
rtl/time_cnt_generator.sv
rtl/modulation.sv
rtl/silencer.sv
rtl/pulse_width_encoder.sv
rtl/pwm.sv
rtl/array_top.sv
tb/tb_array_top.sv

//--- run.sh
#!/bin/sh
# Compile and run the array testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_array_top \
  -o sim_array
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_array > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tb/tb_array_top.sv
`timescale 1ns/1ps
module tb_array_top
  import array_pkg::*;
();

  typedef enum {
    K_WRITE,
    K_READ,
    K_READ_SLOW,
    K_READ_ERR,
    K_STEADY,
    K_PWE,
    K_MOD,
    K_SIL
  } kind_e;

  typedef struct {
    string       name;
    kind_e       kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] expected;
    int          periods;
  } test_row_t;

  localparam int NUM_TESTS = 11;

  logic              clk = 1'b0;
  logic              reset;
  axil_req_t         req;
  axil_rsp_t         axil_rsp;
  logic [NUM_CH-1:0] pwm_out;

  test_row_t   tests [NUM_TESTS];
  logic [31:0] lfsr = 32'he5a0_a9d1;
  int          cycles = 0;
  int          limit;
  int          errors = 0;
  int          drv_int [NUM_CH];
  int          drv_ph [NUM_CH];
  int          pwe_model [PWE_LEN];
  int          scaled [MOD_LEN];
  int          meas_width [NUM_CH];
  int          meas_rise [NUM_CH];
  int          hist_w [64];
  int          hist_r [64];

  array_top UUT (
    .clk(clk),
    .reset(reset),
    .axil_req(req),
    .axil_rsp(axil_rsp),
    .pwm_out(pwm_out)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout after %0d cycles, the run did not finish in time", cycles);
      $display("TB FAILED");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // random numbers and error lines
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);  // one step per bit.
      val = (val << 1) | int'(lfsr[0]);
    end
  endtask

  task automatic report_mismatch(input string name, input int exp, input int act);
    $display("FAIL %s expected %0d actual %0d", name, exp, act);
    errors++;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AXI4-Lite driver, inputs change on the falling edge
  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int   waited;
    logic accepted;
    @(negedge clk);
    req.awaddr  = addr;
    req.awvalid = 1'b1;
    req.wdata   = data;
    req.wstrb   = 4'hf;
    req.wvalid  = 1'b1;
    req.bready  = 1'b1;
    waited      = 0;
    accepted    = 1'b0;
    while (!accepted && waited < 16) begin
      #1;
      accepted = axil_rsp.awready && axil_rsp.wready;  // ready is seen before the edge.
      @(negedge clk);
      waited++;
    end
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    if (!accepted) begin
      $display("write to address %h was never accepted", addr);
      errors++;
    end else if (!axil_rsp.bvalid) begin
      $display("no write response for address %h", addr);
      errors++;
    end
    resp = axil_rsp.bresp;
    @(negedge clk);
    req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr, input int hold,
                           output logic [31:0] data, output logic [1:0] resp);
    int   waited;
    logic accepted;
    @(negedge clk);
    req.araddr  = addr;
    req.arvalid = 1'b1;
    req.rready  = (hold == 0);
    waited      = 0;
    accepted    = 1'b0;
    while (!accepted && waited < 16) begin
      #1;
      accepted = axil_rsp.arready;
      @(negedge clk);
      waited++;
    end
    req.arvalid = 1'b0;
    if (!accepted) begin
      $display("read of address %h was never accepted", addr);
      errors++;
    end else if (!axil_rsp.rvalid) begin
      $display("no read response for address %h", addr);
      errors++;
    end
    if (hold > 0) begin
      repeat (hold) @(negedge clk);
      if (!axil_rsp.rvalid) begin
        $display("rvalid dropped while rready was held low");
        errors++;
      end
      req.rready = 1'b1;
    end
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(negedge clk);
    req.rready = 1'b0;
  endtask

  task automatic write_ok(input logic [31:0] addr, input int data);
    logic [1:0] resp;
    axil_write(addr, 32'(data), resp);
    if (resp != RESP_OKAY) begin
      $display("setup write to %h was refused", addr);
      errors++;
    end
  endtask

  task automatic write_drive(input int ch, input int inten, input int ph);
    drv_int[ch] = inten;
    drv_ph[ch]  = ph;
    write_ok(BASE_DRIVE + 32'(4 * ch), (inten << 8) | ph);
  endtask

  task automatic write_pwe(input int idx, input int width);
    pwe_model[idx] = width;
    write_ok(BASE_PWE + 32'(4 * idx), width);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // measurer, one full period from tick 0 to tick 511
  task automatic measure_period();
    logic [NUM_CH-1:0] seen [CYCLE_T];
    int prev;
    do begin
      @(negedge clk);
    end while (UUT.time_cnt != '0);
    for (int t = 0; t < CYCLE_T; t++) begin
      if (t > 0) begin
        @(negedge clk);
      end
      seen[t] = pwm_out;
    end
    for (int ch = 0; ch < NUM_CH; ch++) begin
      meas_width[ch] = 0;
      meas_rise[ch]  = -1;
      for (int t = 0; t < CYCLE_T; t++) begin
        prev = (t + CYCLE_T - 1) % CYCLE_T;
        if (seen[t][ch]) begin
          meas_width[ch]++;
          if (!seen[prev][ch]) begin
            meas_rise[ch] = t;
          end
        end
      end
    end
  endtask

  // reference model of the encoder and the rise rule.
  task automatic check_channels(input string name);
    int w;
    int r;
    for (int ch = 0; ch < NUM_CH; ch++) begin
      w = pwe_model[drv_int[ch]];
      r = (w == 0) ? -1 : (2 * drv_ph[ch] - w / 2 + CYCLE_T) % CYCLE_T;
      if (meas_width[ch] != w) begin
        report_mismatch($sformatf("%s ch%0d width", name, ch), w, meas_width[ch]);
      end
      if (meas_rise[ch] != r) begin
        report_mismatch($sformatf("%s ch%0d rise", name, ch), r, meas_rise[ch]);
      end
    end
  endtask

  task automatic run_mod_test(input string name, input int periods);
    int runs_v[$];
    int runs_n[$];
    int k;
    int prev_k;
    prev_k = -1;
    for (int i = 0; i < periods; i++) begin
      measure_period();
      if (i >= 3) begin
        if (runs_v.size() == 0 || runs_v[$] != meas_width[0]) begin
          runs_v.push_back(meas_width[0]);
          runs_n.push_back(1);
        end else begin
          runs_n[$] = runs_n[$] + 1;
        end
      end
    end
    if (runs_v.size() < 5) begin
      $display("%s: width changed only %0d times", name, runs_v.size());
      errors++;
    end
    for (int i = 0; i < runs_v.size(); i++) begin
      k = -1;
      for (int j = 0; j < MOD_LEN; j++) begin
        if (scaled[j] == runs_v[i]) begin
          k = j;
        end
      end
      if (i > 0 && prev_k >= 0 && runs_v[i] != scaled[(prev_k + 1) % MOD_LEN]) begin
        report_mismatch({name, " width"}, scaled[(prev_k + 1) % MOD_LEN], runs_v[i]);
      end else if (k < 0) begin
        $display("%s: width %0d is no scaled sample", name, runs_v[i]);
        errors++;
      end
      if (i > 0 && i < runs_v.size() - 1 && runs_n[i] != 2) begin
        report_mismatch({name, " periods per sample"}, 2, runs_n[i]);
      end
      prev_k = k;
    end
  endtask

  task automatic run_sil_test(input string name);
    int first;
    int cw;
    int cp;
    int up;
    int ph;
    first = -1;
    for (int i = 0; i < 20; i++) begin
      measure_period();
      hist_w[i] = meas_width[0];
      hist_r[i] = meas_rise[0];
      if (first < 0 && meas_width[0] != 10) begin
        first = i;
      end
    end
    if (first < 0) begin
      $display("%s: intensity never left its start value", name);
      errors++;
    end else begin
      cw = 10;
      cp = 250;
      for (int i = first; i < 20; i++) begin
        cw = (200 - cw > 16) ? cw + 16 : 200;
        up = (10 - cp + 256) % 256;
        if (up <= 128) begin
          cp = (up > 4) ? (cp + 4) % 256 : 10;
        end else begin
          cp = (256 - up > 4) ? (cp + 252) % 256 : 10;
        end
        ph = ((hist_r[i] + hist_w[i] / 2) % CYCLE_T) / 2;
        if (hist_w[i] != cw) begin
          report_mismatch($sformatf("%s period %0d width", name, i), cw, hist_w[i]);
        end
        if (ph != cp) begin
          report_mismatch($sformatf("%s period %0d phase", name, i), cp, ph);
        end
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test table and main loop
  initial begin
    logic [31:0] data;
    logic [1:0]  resp;
    int          start;
    int          failed;
    int          v;
    tests[0]  = '{"div_write", K_WRITE, ADDR_MOD_DIV, 32'h1234, 32'(RESP_OKAY), 0};
    tests[1]  = '{"step_write", K_WRITE, ADDR_STEP_INT, 32'h5a, 32'(RESP_OKAY), 0};
    tests[2]  = '{"div_read", K_READ, ADDR_MOD_DIV, 32'd0, 32'h1234, 0};
    tests[3]  = '{"step_read_slow", K_READ_SLOW, ADDR_STEP_INT, 32'd6, 32'h5a, 0};
    tests[4]  = '{"unmapped_write", K_WRITE, 32'h014, 32'hff, 32'(RESP_SLVERR), 0};
    tests[5]  = '{"div_after_bad", K_READ, ADDR_MOD_DIV, 32'd0, 32'h1234, 0};
    tests[6]  = '{"unmapped_read", K_READ_ERR, 32'h7f0, 32'd0, 32'(RESP_SLVERR), 0};
    tests[7]  = '{"steady_drive", K_STEADY, 32'd0, 32'd0, 32'd0, 3};
    tests[8]  = '{"pwe_table", K_PWE, 32'd0, 32'd0, 32'd0, 3};
    tests[9]  = '{"modulation", K_MOD, 32'd0, 32'd0, 32'd0, 40};
    tests[10] = '{"silencer", K_SIL, 32'd0, 32'd0, 32'd0, 23};
    limit = 2000;
    for (int i = 0; i < NUM_TESTS; i++) begin
      if (tests[i].periods > 0) begin
        limit += (tests[i].periods + 2) * CYCLE_T;  // alignment and setup time.
      end
    end
    req    = '0;
    reset  = 1'b1;
    failed = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < NUM_TESTS; i++) begin
      start = errors;
      case (tests[i].kind)
        K_WRITE: begin
          axil_write(tests[i].addr, tests[i].data, resp);
          if (32'(resp) != tests[i].expected) begin
            report_mismatch(tests[i].name, int'(tests[i].expected), int'(resp));
          end
        end
        K_READ, K_READ_SLOW, K_READ_ERR: begin
          axil_read(tests[i].addr, (tests[i].kind == K_READ_SLOW) ? int'(tests[i].data) : 0,
                    data, resp);
          if (tests[i].kind == K_READ_ERR) begin
            if (32'(resp) != tests[i].expected) begin
              report_mismatch(tests[i].name, int'(tests[i].expected), int'(resp));
            end
          end else begin
            if (data != tests[i].expected) begin
              report_mismatch(tests[i].name, int'(tests[i].expected), int'(data));
            end
            if (resp != RESP_OKAY) begin
              report_mismatch({tests[i].name, " resp"}, int'(RESP_OKAY), int'(resp));
            end
          end
        end
        K_STEADY, K_PWE: begin
          if (tests[i].kind == K_STEADY) begin
            write_ok(ADDR_CTRL, 0);
            write_ok(ADDR_MOD_DIV, 0);
            write_ok(ADDR_STEP_INT, 0);
            write_ok(ADDR_STEP_PH, 0);
          end
          for (int ch = 0; ch < NUM_CH; ch++) begin
            if (tests[i].kind == K_STEADY) begin
              take_bits(8, v);
              drv_int[ch] = v;
              take_bits(8, v);
              write_drive(ch, drv_int[ch], v);
              write_pwe(drv_int[ch], drv_int[ch]);  // identity table.
            end else begin
              write_pwe(drv_int[ch], ((drv_int[ch] * drv_int[ch]) >> 7) + 1);
            end
          end
          repeat (tests[i].periods) measure_period();
          check_channels(tests[i].name);
        end
        K_MOD: begin
          write_drive(0, 200, 64);
          for (int k = 0; k < MOD_LEN; k++) begin
            scaled[k] = (200 * (16 * k + 15)) >> 8;
            write_ok(BASE_MOD + 32'(4 * k), 16 * k + 15);
            write_pwe(scaled[k], scaled[k]);
          end
          write_ok(ADDR_MOD_DIV, 1);
          write_ok(ADDR_CTRL, 1);
          run_mod_test(tests[i].name, tests[i].periods);
        end
        K_SIL: begin
          write_ok(ADDR_CTRL, 0);
          write_ok(ADDR_STEP_INT, 0);
          write_ok(ADDR_STEP_PH, 0);
          write_drive(0, 10, 250);
          for (int k = 0; k < 12; k++) begin
            write_pwe(10 + 16 * k, 10 + 16 * k);
          end
          write_pwe(200, 200);
          repeat (3) measure_period();
          write_ok(ADDR_STEP_INT, 16);
          write_ok(ADDR_STEP_PH, 4);
          write_drive(0, 200, 10);
          run_sil_test(tests[i].name);
        end
        default: begin
          $display("test %s has an unknown kind", tests[i].name);
          errors++;
        end
      endcase
      if (errors == start) begin
        $display("test %s finished ok", tests[i].name);
      end else begin
        $display("test %s finished with %0d errors", tests[i].name, errors - start);
        failed++;
      end
    end

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             NUM_TESTS, NUM_TESTS - failed, failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- rtl/array_top.sv
`timescale 1ns/1ps
module array_top
  import array_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  axil_req_t         axil_req,
  output axil_rsp_t         axil_rsp,
  output logic [NUM_CH-1:0] pwm_out
);

  mod_settings_t      mod_settings;
  silencer_settings_t silencer_settings;

  logic [CNT_W-1:0] time_cnt;
  logic             update;

  logic [CH_W-1:0]  drive_addr;
  drive_t           drive_data;
  logic [MOD_W-1:0] mod_addr;
  logic [7:0]       mod_data;
  logic [7:0]       pwe_addr;
  logic [CNT_W-1:0] pwe_data;

  chan_stream_t  stream_m;
  chan_stream_t  stream_s;
  pulse_stream_t stream_e;

  axil_config axil_config (
    .clk(clk),
    .reset(reset),
    .axil_req(axil_req),
    .axil_rsp(axil_rsp),
    .mod_settings(mod_settings),
    .silencer_settings(silencer_settings),
    .drive_addr(drive_addr),
    .drive_data(drive_data),
    .mod_addr(mod_addr),
    .mod_data(mod_data),
    .pwe_addr(pwe_addr),
    .pwe_data(pwe_data)
  );

  time_cnt_generator time_cnt_generator (
    .clk(clk),
    .reset(reset),
    .time_cnt(time_cnt),
    .update(update)
  );

  modulation modulation (
    .clk(clk),
    .reset(reset),
    .update(update),
    .mod_settings(mod_settings),
    .drive_addr(drive_addr),
    .drive_data(drive_data),
    .mod_addr(mod_addr),
    .mod_data(mod_data),
    .dout(stream_m)
  );

  silencer silencer (
    .clk(clk),
    .reset(reset),
    .silencer_settings(silencer_settings),
    .din(stream_m),
    .dout(stream_s)
  );

  pulse_width_encoder pulse_width_encoder (
    .clk(clk),
    .reset(reset),
    .din(stream_s),
    .pwe_addr(pwe_addr),
    .pwe_data(pwe_data),
    .dout(stream_e)
  );

  pwm pwm (
    .clk(clk),
    .reset(reset),
    .time_cnt(time_cnt),
    .update(update),
    .din(stream_e),
    .pwm_out(pwm_out)
  );

endmodule

//--- rtl/pwm.sv
`timescale 1ns/1ps
module pwm
  import array_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  logic [CNT_W-1:0]  time_cnt,
  input  logic              update,
  input  pulse_stream_t     din,
  output logic [NUM_CH-1:0] pwm_out
);

  pulse_t shadow [NUM_CH];
  pulse_t active [NUM_CH];

  // the window is centred on twice the phase.
  function automatic logic in_window(input logic [CNT_W-1:0] t, input pulse_t p);
    logic [CNT_W-1:0] rise;
    logic [CNT_W-1:0] offset;
    rise   = {p.phase, 1'b0} - {1'b0, p.width[CNT_W-1:1]};
    offset = t - rise;
    return offset < p.width;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_CH; i++) begin
        shadow[i] <= '0;
        active[i] <= '0;
      end
    end else begin
      if (din.valid) begin
        shadow[din.ch] <= din.pulse;
      end
      if (update) begin
        active <= shadow;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // comparators
  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      pwm_out[i] = in_window(time_cnt, update ? shadow[i] : active[i]);  // tick 0 sees the new set.
    end
  end

endmodule

//--- rtl/pulse_width_encoder.sv
`timescale 1ns/1ps
module pulse_width_encoder
  import array_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  chan_stream_t     din,
  output logic [7:0]       pwe_addr,
  input  logic [CNT_W-1:0] pwe_data,
  output pulse_stream_t    dout
);

  logic            d_valid;
  logic [CH_W-1:0] d_ch;
  logic [7:0]      d_phase;

  assign pwe_addr = din.drive.intensity;

  // channel and phase wait one cycle for the table read.
  always_ff @(posedge clk) begin
    if (reset) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= din.valid;
      d_ch    <= din.ch;
      d_phase <= din.drive.phase;
    end
  end

  always_comb begin
    dout.valid       = d_valid;
    dout.ch          = d_ch;
    dout.pulse.width = pwe_data;
    dout.pulse.phase = d_phase;
  end

endmodule

//--- rtl/silencer.sv
`timescale 1ns/1ps
module silencer
  import array_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  silencer_settings_t silencer_settings,
  input  chan_stream_t       din,
  output chan_stream_t       dout
);

  logic [7:0] cur_int [NUM_CH];
  logic [7:0] cur_ph [NUM_CH];
  logic [7:0] next_int;
  logic [7:0] next_ph;

  function automatic logic [7:0] move_int(input logic [7:0] cur, input logic [7:0] tgt,
                                          input logic [7:0] step);
    if (step == 8'd0) begin
      return tgt;
    end
    if (tgt >= cur) begin
      return (tgt - cur > step) ? cur + step : tgt;
    end
    return (cur - tgt > step) ? cur - step : tgt;
  endfunction

  // phase wraps at 256, so it takes the shorter way round.
  function automatic logic [7:0] move_phase(input logic [7:0] cur, input logic [7:0] tgt,
                                            input logic [7:0] step);
    logic [7:0] up;
    logic [7:0] down;
    up   = tgt - cur;
    down = cur - tgt;
    if (step == 8'd0 || up == 8'd0) begin
      return tgt;
    end
    if (up <= 8'd128) begin
      return (up > step) ? cur + step : tgt;  // a tie of 128 goes up.
    end
    return (down > step) ? cur - step : tgt;
  endfunction

  always_comb begin
    next_int = move_int(cur_int[din.ch], din.drive.intensity, silencer_settings.step_intensity);
    next_ph  = move_phase(cur_ph[din.ch], din.drive.phase, silencer_settings.step_phase);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dout.valid <= 1'b0;
      for (int i = 0; i < NUM_CH; i++) begin
        cur_int[i] <= '0;
        cur_ph[i]  <= '0;
      end
    end else begin
      dout.valid           <= din.valid;
      dout.ch              <= din.ch;
      dout.drive.intensity <= next_int;
      dout.drive.phase     <= next_ph;
      if (din.valid) begin
        cur_int[din.ch] <= next_int;
        cur_ph[din.ch]  <= next_ph;
      end
    end
  end

endmodule

//--- rtl/modulation.sv
`timescale 1ns/1ps
module modulation
  import array_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  input  logic             update,
  input  mod_settings_t    mod_settings,
  output logic [CH_W-1:0]  drive_addr,
  input  drive_t           drive_data,
  output logic [MOD_W-1:0] mod_addr,
  input  logic [7:0]       mod_data,
  output chan_stream_t     dout
);

  logic [15:0]      div_cnt;
  logic [MOD_W-1:0] idx;
  logic             busy;
  logic [CH_W-1:0]  rd_ch;
  logic             rd_valid;
  logic [CH_W-1:0]  rd_ch_d;
  logic [15:0]      product;

  assign drive_addr = rd_ch;
  assign mod_addr   = idx;
  assign product    = drive_data.intensity * mod_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      div_cnt <= '0;
      idx     <= '0;
    end else if (update) begin
      if (!mod_settings.enable) begin
        div_cnt <= '0;
        idx     <= '0;
      end else if (div_cnt == mod_settings.div) begin
        div_cnt <= '0;
        idx     <= idx + 1'b1;  // wraps at MOD_LEN.
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // channel stream, one drive read per cycle after update
  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      rd_ch    <= '0;
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= busy;
      rd_ch_d  <= rd_ch;
      if (update) begin
        busy  <= 1'b1;
        rd_ch <= '0;
      end else if (busy) begin
        rd_ch <= rd_ch + 1'b1;
        if (rd_ch == CH_W'(NUM_CH - 1)) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dout.valid <= 1'b0;
    end else begin
      dout.valid           <= rd_valid;
      dout.ch              <= rd_ch_d;
      dout.drive.phase     <= drive_data.phase;
      dout.drive.intensity <= mod_settings.enable ? product[15:8] : drive_data.intensity;
    end
  end

endmodule

//--- rtl/time_cnt_generator.sv
`timescale 1ns/1ps
module time_cnt_generator
  import array_pkg::*;
(
  input  logic             clk,
  input  logic             reset,
  output logic [CNT_W-1:0] time_cnt,
  output logic             update
);

  always_ff @(posedge clk) begin
    if (reset) begin
      time_cnt <= '0;
    end else if (time_cnt == CNT_W'(CYCLE_T - 1)) begin
      time_cnt <= '0;
    end else begin
      time_cnt <= time_cnt + 1'b1;
    end
  end

  // one cycle at the start of every period.
  assign update = (time_cnt == '0);

endmodule

//--- rtl/axil_config.sv
`timescale 1ns/1ps
module axil_config
  import array_pkg::*;
(
  input  logic               clk,
  input  logic               reset,
  input  axil_req_t          axil_req,
  output axil_rsp_t          axil_rsp,
  output mod_settings_t      mod_settings,
  output silencer_settings_t silencer_settings,
  input  logic [CH_W-1:0]    drive_addr,
  output drive_t             drive_data,
  input  logic [MOD_W-1:0]   mod_addr,
  output logic [7:0]         mod_data,
  input  logic [7:0]         pwe_addr,
  output logic [CNT_W-1:0]   pwe_data
);

  axil_state_e state;

  drive_t           drive_mem [NUM_CH];
  logic [7:0]       mod_mem [MOD_LEN];
  logic [CNT_W-1:0] pwe_mem [PWE_LEN];

  logic        wr_fire;
  logic        rd_fire;
  logic        wr_drive;
  logic        wr_mod;
  logic        wr_pwe;
  logic        wr_hit;
  logic        rd_hit;
  logic [31:0] rd_value;
  logic [31:0] wmask;
  logic [31:0] wmasked;
  logic        bvalid;
  logic        rvalid;
  logic [1:0]  bresp;
  logic [1:0]  rresp;
  logic [31:0] rdata;

  function automatic logic in_table(input logic [31:0] addr, input logic [31:0] base,
                                    input int unsigned len);
    return (addr >= base) && (addr < base + 32'(4 * len));
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decode
  always_comb begin
    wr_fire  = (state == IDLE) && axil_req.awvalid && axil_req.wvalid;
    rd_fire  = (state == IDLE) && axil_req.arvalid && !wr_fire;  // writes win a tie.
    for (int i = 0; i < 4; i++) begin
      wmask[8*i +: 8] = {8{axil_req.wstrb[i]}};
    end
    wmasked  = axil_req.wdata & wmask;
    wr_drive = in_table(axil_req.awaddr, BASE_DRIVE, NUM_CH);
    wr_mod   = in_table(axil_req.awaddr, BASE_MOD, MOD_LEN);
    wr_pwe   = in_table(axil_req.awaddr, BASE_PWE, PWE_LEN);
    wr_hit   = wr_drive || wr_mod || wr_pwe ||
               (axil_req.awaddr inside {ADDR_CTRL, ADDR_MOD_DIV, ADDR_STEP_INT, ADDR_STEP_PH});
    rd_hit   = 1'b1;
    rd_value = '0;
    case (axil_req.araddr)
      ADDR_CTRL:     rd_value = {31'd0, mod_settings.enable};
      ADDR_MOD_DIV:  rd_value = {16'd0, mod_settings.div};
      ADDR_STEP_INT: rd_value = {24'd0, silencer_settings.step_intensity};
      ADDR_STEP_PH:  rd_value = {24'd0, silencer_settings.step_phase};
      default: begin
        rd_hit = in_table(axil_req.araddr, BASE_DRIVE, NUM_CH) ||
                 in_table(axil_req.araddr, BASE_MOD, MOD_LEN) ||
                 in_table(axil_req.araddr, BASE_PWE, PWE_LEN);  // tables read back as 0.
      end
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // handshake FSM
  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= IDLE;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
      bresp  <= RESP_OKAY;
      rresp  <= RESP_OKAY;
      rdata  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (wr_fire) begin
            state  <= WRITE_RESP;
            bvalid <= 1'b1;
            bresp  <= wr_hit ? RESP_OKAY : RESP_SLVERR;
          end else if (rd_fire) begin
            state  <= READ_RESP;
            rvalid <= 1'b1;
            rresp  <= rd_hit ? RESP_OKAY : RESP_SLVERR;
            rdata  <= rd_value;
          end
        end
        WRITE_RESP: begin
          if (axil_req.bready) begin
            state  <= IDLE;
            bvalid <= 1'b0;
          end
        end
        READ_RESP: begin
          if (axil_req.rready) begin
            state  <= IDLE;
            rvalid <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // registers and tables, merged byte by byte under wstrb.
  always_ff @(posedge clk) begin
    if (reset) begin
      mod_settings      <= '0;
      silencer_settings <= '0;
      for (int i = 0; i < NUM_CH; i++) begin
        drive_mem[i] <= '0;
      end
      for (int i = 0; i < MOD_LEN; i++) begin
        mod_mem[i] <= '0;
      end
      for (int i = 0; i < PWE_LEN; i++) begin
        pwe_mem[i] <= '0;
      end
    end else if (wr_fire) begin
      case (axil_req.awaddr)
        ADDR_CTRL:     mod_settings.enable <= (mod_settings.enable & ~wmask[0]) | wmasked[0];
        ADDR_MOD_DIV:  mod_settings.div <= (mod_settings.div & ~wmask[15:0]) | wmasked[15:0];
        ADDR_STEP_INT: silencer_settings.step_intensity <=
            (silencer_settings.step_intensity & ~wmask[7:0]) | wmasked[7:0];
        ADDR_STEP_PH:  silencer_settings.step_phase <=
            (silencer_settings.step_phase & ~wmask[7:0]) | wmasked[7:0];
        default: begin
          if (wr_drive) begin
            drive_mem[axil_req.awaddr[CH_W+1:2]] <=
                (drive_mem[axil_req.awaddr[CH_W+1:2]] & ~wmask[15:0]) | wmasked[15:0];
          end
          if (wr_mod) begin
            mod_mem[axil_req.awaddr[MOD_W+1:2]] <=
                (mod_mem[axil_req.awaddr[MOD_W+1:2]] & ~wmask[7:0]) | wmasked[7:0];
          end
          if (wr_pwe) begin
            pwe_mem[axil_req.awaddr[9:2]] <=
                (pwe_mem[axil_req.awaddr[9:2]] & ~wmask[CNT_W-1:0]) | wmasked[CNT_W-1:0];
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    drive_data <= drive_mem[drive_addr];  // pipeline read ports.
    mod_data   <= mod_mem[mod_addr];
    pwe_data   <= pwe_mem[pwe_addr];
  end

  always_comb begin
    axil_rsp.awready = wr_fire;
    axil_rsp.wready  = wr_fire;
    axil_rsp.bresp   = bresp;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.arready = rd_fire;
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = rresp;
    axil_rsp.rvalid  = rvalid;
  end

endmodule

//--- rtl/array_pkg.sv
package array_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sizes
  localparam int NUM_CH  = 8;
  localparam int CH_W    = $clog2(NUM_CH);
  localparam int CYCLE_T = 512;
  localparam int CNT_W   = $clog2(CYCLE_T);
  localparam int MOD_LEN = 16;
  localparam int MOD_W   = $clog2(MOD_LEN);
  localparam int PWE_LEN = 256;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address map
  localparam logic [31:0] ADDR_CTRL     = 32'h000;  // bit 0 enables modulation.
  localparam logic [31:0] ADDR_MOD_DIV  = 32'h004;
  localparam logic [31:0] ADDR_STEP_INT = 32'h008;
  localparam logic [31:0] ADDR_STEP_PH  = 32'h00C;
  localparam logic [31:0] BASE_MOD      = 32'h100;  // sample in bits 7:0.
  localparam logic [31:0] BASE_DRIVE    = 32'h200;  // intensity in 15:8 and phase in 7:0.
  localparam logic [31:0] BASE_PWE      = 32'h800;  // pulse width in bits 8:0.

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // AXI4-Lite channels
  typedef struct packed {
    logic [31:0] awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } axil_rsp_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // pipeline data
  typedef struct packed {
    logic [7:0] intensity;
    logic [7:0] phase;
  } drive_t;

  typedef struct packed {
    logic [CNT_W-1:0] width;
    logic [7:0]       phase;
  } pulse_t;

  typedef struct packed {
    logic        enable;
    logic [15:0] div;
  } mod_settings_t;

  typedef struct packed {
    logic [7:0] step_intensity;
    logic [7:0] step_phase;
  } silencer_settings_t;

  typedef struct packed {
    logic            valid;
    logic [CH_W-1:0] ch;
    drive_t          drive;
  } chan_stream_t;

  typedef struct packed {
    logic            valid;
    logic [CH_W-1:0] ch;
    pulse_t          pulse;
  } pulse_stream_t;

  typedef enum logic [1:0] {
    IDLE,
    WRITE_RESP,
    READ_RESP
  } axil_state_e;

endpackage
